/* verilog.f */
+incdir+src
src/axi_pkg.sv
src/dcache_pkg.sv
src/dcache_miss_ctrl.sv
src/dcache_line_buffer.sv
src/axi_dcache.sv
src/dcache_axi_top.sv
bench/axi_mem_model.sv
bench/tb_dcache_axi.sv

/* Bender.yml */
package:
  name: dcache_axi

sources:
  - include_dirs:
      - src
    files:
      - src/axi_pkg.sv
      - src/dcache_pkg.sv
      - src/dcache_miss_ctrl.sv
      - src/dcache_line_buffer.sv
      - src/axi_dcache.sv
      - src/dcache_axi_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/axi_mem_model.sv
      - bench/tb_dcache_axi.sv

/* bench/tb_dcache_axi.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache_axi
    import axi_pkg::*;
();

    localparam logic [31:0] ERR_LO  = 32'h0000_8000;
    localparam logic [31:0] ERR_HI  = 32'h0000_8100;
    localparam int          TIMEOUT = 2000;   // cycles per wait

    logic clock = 1'b0;
    logic reset;
    logic refill_valid, refill_ready, refill_done, refill_err;
    logic wb_valid, wb_ready, wb_done, wb_err;
    logic [31:0]  refill_addr, wb_addr;
    logic [255:0] refill_line, wb_line;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;
    axi_ar_t ar;
    axi_r_t  r;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;

    logic [256:0] refill_exp_q [$];   // err bit above the line
    logic [26:0]  refill_line_q [$];  // lines with a refill outstanding
    logic         wb_exp_q [$];
    logic [255:0] shadow [logic [26:0]];
    logic [31:0]  rng_state = 32'd53;
    int           w_beat = 0;         // W beat index within a burst

    always #4 clock = ~clock;

    dcache_axi_top i_dut (
        .clock, .reset,
        .refill_valid_i(refill_valid), .refill_addr_i(refill_addr),
        .refill_ready_o(refill_ready), .refill_done_o(refill_done),
        .refill_line_o(refill_line), .refill_err_o(refill_err),
        .wb_valid_i(wb_valid), .wb_addr_i(wb_addr), .wb_line_i(wb_line),
        .wb_ready_o(wb_ready), .wb_done_o(wb_done), .wb_err_o(wb_err),
        .axi_aw_o(aw), .axi_aw_valid_o(aw_valid), .axi_aw_ready_i(aw_ready),
        .axi_w_o(w), .axi_w_valid_o(w_valid), .axi_w_ready_i(w_ready),
        .axi_b_i(b), .axi_b_valid_i(b_valid), .axi_b_ready_o(b_ready),
        .axi_ar_o(ar), .axi_ar_valid_o(ar_valid), .axi_ar_ready_i(ar_ready),
        .axi_r_i(r), .axi_r_valid_i(r_valid), .axi_r_ready_o(r_ready)
    );

    axi_mem_model #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) u_mem (
        .clock, .reset,
        .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready)
    );

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [255:0] random_line();
        logic [255:0] v;
        for (int i = 0; i < 8; i++) v[32*i +: 32] = xorshift32();
        return v;
    endfunction

    function automatic logic in_err_window(input logic [31:0] a);
        return (a >= ERR_LO) && (a < ERR_HI);
    endfunction

    // expected line is the last written data or the memory fill pattern
    function automatic logic [255:0] expected_line(input logic [31:0] a);
        logic [255:0] v;
        logic [31:0]  ba;
        if (shadow.exists(a[31:5])) return shadow[a[31:5]];
        for (int i = 0; i < 4; i++) begin
            ba = {a[31:5], 5'd0} + 32'(8 * i);
            v[64*i +: 64] = {ba ^ 32'h5A5A_C3C3, ba * 32'h9E37_79B1};
        end
        return v;
    endfunction

    function automatic logic refill_pending(input logic [26:0] line_addr);
        foreach (refill_line_q[i]) if (refill_line_q[i] == line_addr) return 1'b1;
        return 1'b0;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    // a four-beat INCR line burst with the fixed attributes
    task automatic check_addr_channel(input string chan, input axi_aw_t a,
                                      input logic [3:0] exp_cache);
        check_value({chan, ".addr offset"}, 256'(a.addr[4:0]), 256'(0));
        check_value({chan, ".id"}, 256'(a.id), 256'(`DC_AXI_ID));
        check_value({chan, ".len"}, 256'(a.len), 256'(`DC_LINE_BEATS - 1));
        check_value({chan, ".size"}, 256'(a.size), 256'($clog2(`DC_BEAT_W / 8)));
        check_value({chan, ".burst"}, 256'(a.burst), 256'(2'b01));
        check_value({chan, ".cache"}, 256'(a.cache), 256'(exp_cache));
        check_value({chan, ".prot"}, 256'(a.prot), 256'(`DC_PROT));
    endtask

    task automatic issue_refill(input logic [31:0] addr);
        int n;
        n = 0;
        refill_valid = 1'b1;
        refill_addr  = addr;
        @(negedge clock);
        while (!refill_ready) begin
            n++;
            if (n > TIMEOUT) fail_run("refill request was never accepted");
            @(negedge clock);
        end
        refill_exp_q.push_back({in_err_window(addr), expected_line(addr)});
        refill_line_q.push_back(addr[31:5]);
        @(posedge clock);
        #1;
        refill_valid = 1'b0;
    endtask

    task automatic issue_wb(input logic [31:0] addr, input logic [255:0] line);
        int n;
        n = 0;
        wb_valid = 1'b1;
        wb_addr  = addr;
        wb_line  = line;
        @(negedge clock);
        while (!wb_ready) begin
            n++;
            if (n > TIMEOUT) fail_run("writeback request was never accepted");
            @(negedge clock);
        end
        if (!in_err_window(addr)) shadow[addr[31:5]] = line;
        wb_exp_q.push_back(in_err_window(addr));
        @(posedge clock);
        #1;
        wb_valid = 1'b0;
    endtask

    task automatic wait_all_done();
        int n;
        n = 0;
        while (refill_exp_q.size() != 0 || wb_exp_q.size() != 0) begin
            n++;
            if (n > TIMEOUT) begin
                if (refill_exp_q.size() != 0) fail_run("refill_done_o never came");
                else fail_run("wb_done_o never came");
            end
            @(posedge clock);
        end
        #1;
    endtask

    always @(negedge clock) begin : compare
        logic [256:0] exp;
        if (reset && refill_done) begin
            if (refill_exp_q.size() == 0) fail_run("refill_done_o pulsed with no refill open");
            exp = refill_exp_q.pop_front();
            void'(refill_line_q.pop_front());
            check_value("refill_line_o", refill_line, exp[255:0]);
            check_value("refill_err_o", 256'(refill_err), 256'(exp[256]));
        end
        if (reset && wb_done) begin
            if (wb_exp_q.size() == 0) fail_run("wb_done_o pulsed with no writeback open");
            check_value("wb_err_o", 256'(wb_err), 256'(wb_exp_q.pop_front()));
        end
        if (reset && aw_valid && aw_ready) begin
            check_addr_channel("axi_aw_o", aw, `DC_AWCACHE);
        end
        if (reset && ar_valid && ar_ready) begin
            check_addr_channel("axi_ar_o", axi_aw_t'(ar), `DC_ARCACHE);
        end
        if (reset && w_valid && w_ready) begin
            check_value("axi_w_o.strb", 256'(w.strb), 256'(8'hFF));   // every byte written
            check_value("axi_w_o.last", 256'(w.last), 256'(w_beat == `DC_LINE_BEATS - 1));
            w_beat = (w_beat + 1) % `DC_LINE_BEATS;
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        reset        = 1'b0;
        refill_valid = 1'b0;
        refill_addr  = '0;
        wb_valid     = 1'b0;
        wb_addr      = '0;
        wb_line      = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;
        @(posedge clock);
        #1;
        issue_refill(32'h0000_1040);                  // aligned refill
        wait_all_done();
        issue_refill(32'h0000_105C);                  // offset bits dropped
        wait_all_done();
        issue_wb(32'h0000_1040, random_line());
        issue_refill(32'h0000_1048);                  // blocked until B
        wait_all_done();
        fork
            issue_refill(32'h0000_1100);
            issue_wb(32'h0000_1200, random_line());
        join
        wait_all_done();
        fork
            issue_refill(ERR_LO + 32'h20);
            issue_wb(ERR_LO + 32'h40, random_line());
        join
        wait_all_done();
        for (int i = 0; i < 60; i++) begin
            addr = 32'h0000_1000 + (xorshift32() % 512);   // 16 lines with random offsets
            if (xorshift32() % 2) begin
                if (refill_pending(addr[31:5])) wait_all_done();
                issue_wb(addr, random_line());
            end else begin
                issue_refill(addr);
            end
        end
        wait_all_done();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* bench/axi_mem_model.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module axi_mem_model
    import axi_pkg::*;
#(
    parameter logic [31:0] ERR_LO = 32'h0000_8000,
    parameter logic [31:0] ERR_HI = 32'h0000_8100
) (
    input  logic    clock,
    input  logic    reset,
    input  axi_aw_t aw_i,
    input  logic    aw_valid_i,
    output logic    aw_ready_o,
    input  axi_w_t  w_i,
    input  logic    w_valid_i,
    output logic    w_ready_o,
    output axi_b_t  b_o,
    output logic    b_valid_o,
    input  logic    b_ready_i,
    input  axi_ar_t ar_i,
    input  logic    ar_valid_i,
    output logic    ar_ready_o,
    output axi_r_t  r_o,
    output logic    r_valid_o,
    input  logic    r_ready_i
);

    logic [63:0] mem [logic [31:0]];   // write shadow, keyed by beat address
    logic [31:0] rng_state = 32'd53;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [63:0] read_word(input logic [31:0] a);
        if (mem.exists(a)) return mem[a];
        return {a ^ 32'h5A5A_C3C3, a * 32'h9E37_79B1};   // fill pattern
    endfunction

    // 0 to 3 idle cycles, then lands 1 ns after a rising edge
    task automatic random_delay();
        repeat (xorshift32() % 4) @(posedge clock);
        @(posedge clock);
        #1;
    endtask

    initial begin : write_side
        logic [31:0] addr;
        logic        err;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        b_o        = '0;
        @(posedge reset);
        forever begin
            @(negedge clock);
            if (aw_valid_i) begin
                random_delay();
                aw_ready_o = 1'b1;
                addr = aw_i.addr;
                err  = (addr >= ERR_LO) && (addr < ERR_HI);
                @(posedge clock);
                #1;
                aw_ready_o = 1'b0;
                for (int i = 0; i < `DC_LINE_BEATS; i++) begin
                    random_delay();
                    w_ready_o = 1'b1;
                    @(negedge clock);
                    while (!w_valid_i) @(negedge clock);
                    if (!err) mem[addr + 32'(8 * i)] = w_i.data;   // failed writes are dropped
                    @(posedge clock);
                    #1;
                    w_ready_o = 1'b0;
                end
                random_delay();
                b_o       = '{resp: (err ? 2'b10 : 2'b00), id: `DC_AXI_ID};
                b_valid_o = 1'b1;
                @(negedge clock);
                while (!b_ready_i) @(negedge clock);
                @(posedge clock);
                #1;
                b_valid_o = 1'b0;
            end
        end
    end

    initial begin : read_side
        logic [31:0] addr;
        logic        err;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
        @(posedge reset);
        forever begin
            @(negedge clock);
            if (ar_valid_i) begin
                random_delay();
                ar_ready_o = 1'b1;
                addr = ar_i.addr;
                err  = (addr >= ERR_LO) && (addr < ERR_HI);
                @(posedge clock);
                #1;
                ar_ready_o = 1'b0;
                for (int i = 0; i < `DC_LINE_BEATS; i++) begin
                    random_delay();
                    r_o = '{data: read_word(addr + 32'(8 * i)), resp: (err ? 2'b10 : 2'b00),
                            last: (i == `DC_LINE_BEATS - 1), id: `DC_AXI_ID};
                    r_valid_o = 1'b1;
                    @(negedge clock);
                    while (!r_ready_i) @(negedge clock);
                    @(posedge clock);
                    #1;
                    r_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* src/dcache_axi_top.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_axi_top
    import axi_pkg::*;
    import dcache_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  refill_valid_i,
    input  logic [`DC_ADDR_W-1:0] refill_addr_i,
    output logic                  refill_ready_o,
    output logic                  refill_done_o,
    output logic [`DC_LINE_W-1:0] refill_line_o,
    output logic                  refill_err_o,
    input  logic                  wb_valid_i,
    input  logic [`DC_ADDR_W-1:0] wb_addr_i,
    input  logic [`DC_LINE_W-1:0] wb_line_i,
    output logic                  wb_ready_o,
    output logic                  wb_done_o,
    output logic                  wb_err_o,
    output axi_aw_t               axi_aw_o,
    output logic                  axi_aw_valid_o,
    input  logic                  axi_aw_ready_i,
    output axi_w_t                axi_w_o,
    output logic                  axi_w_valid_o,
    input  logic                  axi_w_ready_i,
    input  axi_b_t                axi_b_i,
    input  logic                  axi_b_valid_i,
    output logic                  axi_b_ready_o,
    output axi_ar_t               axi_ar_o,
    output logic                  axi_ar_valid_o,
    input  logic                  axi_ar_ready_i,
    input  axi_r_t                axi_r_i,
    input  logic                  axi_r_valid_i,
    output logic                  axi_r_ready_o
);

    line_req_t             rd_req, wr_req;
    logic                  rd_req_valid, rd_req_taken;
    logic                  wr_req_valid, wr_req_taken;
    logic                  wb_load;
    line_data_u            wb_line;
    logic [`DC_BEAT_W-1:0] w_data;
    logic                  w_last, w_beat_adv;
    logic                  r_beat_valid;
    axi_r_t                r_beat;
    logic                  b_done;
    resp_e                 b_resp;

    dcache_miss_ctrl u_miss_ctrl (
        .clock, .reset, .refill_valid_i, .refill_addr_i, .refill_ready_o,
        .wb_valid_i, .wb_addr_i, .wb_line_i, .wb_ready_o,
        .rd_req_o(rd_req), .rd_req_valid_o(rd_req_valid), .rd_req_taken_i(rd_req_taken),
        .wr_req_o(wr_req), .wr_req_valid_o(wr_req_valid), .wr_req_taken_i(wr_req_taken),
        .b_done_i(b_done), .wb_load_o(wb_load), .wb_line_o(wb_line)
    );

    dcache_line_buffer u_line_buffer (
        .clock, .reset, .wb_load_i(wb_load), .wb_line_i(wb_line),
        .w_beat_adv_i(w_beat_adv), .w_data_o(w_data), .w_last_o(w_last),
        .r_beat_valid_i(r_beat_valid), .r_beat_i(r_beat),
        .b_done_i(b_done), .b_resp_i(b_resp),
        .refill_done_o, .refill_line_o, .refill_err_o, .wb_done_o, .wb_err_o
    );

    axi_dcache u_axi_master (
        .clock, .reset,
        .rd_req_i(rd_req), .rd_req_valid_i(rd_req_valid), .rd_req_taken_o(rd_req_taken),
        .wr_req_i(wr_req), .wr_req_valid_i(wr_req_valid), .wr_req_taken_o(wr_req_taken),
        .w_data_i(w_data), .w_last_i(w_last), .w_beat_adv_o(w_beat_adv),
        .r_beat_valid_o(r_beat_valid), .r_beat_o(r_beat),
        .b_done_o(b_done), .b_resp_o(b_resp),
        .axi_aw_o, .axi_aw_valid_o, .axi_aw_ready_i,
        .axi_w_o, .axi_w_valid_o, .axi_w_ready_i,
        .axi_b_i, .axi_b_valid_i, .axi_b_ready_o,
        .axi_ar_o, .axi_ar_valid_o, .axi_ar_ready_i,
        .axi_r_i, .axi_r_valid_i, .axi_r_ready_o
    );

endmodule

/* src/axi_dcache.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module axi_dcache
    import axi_pkg::*;
    import dcache_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  line_req_t             rd_req_i,
    input  logic                  rd_req_valid_i,
    output logic                  rd_req_taken_o,
    input  line_req_t             wr_req_i,
    input  logic                  wr_req_valid_i,
    output logic                  wr_req_taken_o,
    input  logic [`DC_BEAT_W-1:0] w_data_i,
    input  logic                  w_last_i,
    output logic                  w_beat_adv_o,
    output logic                  r_beat_valid_o,
    output axi_r_t                r_beat_o,
    output logic                  b_done_o,
    output resp_e                 b_resp_o,
    output axi_aw_t               axi_aw_o,
    output logic                  axi_aw_valid_o,
    input  logic                  axi_aw_ready_i,
    output axi_w_t                axi_w_o,
    output logic                  axi_w_valid_o,
    input  logic                  axi_w_ready_i,
    input  axi_b_t                axi_b_i,
    input  logic                  axi_b_valid_i,
    output logic                  axi_b_ready_o,
    output axi_ar_t               axi_ar_o,
    output logic                  axi_ar_valid_o,
    input  logic                  axi_ar_ready_i,
    input  axi_r_t                axi_r_i,
    input  logic                  axi_r_valid_i,
    output logic                  axi_r_ready_o
);

    typedef enum logic [1:0] {W_IDLE, W_AW, W_DATA, W_B} w_state_e;
    typedef enum logic [1:0] {R_IDLE, R_AR, R_DATA} r_state_e;

    w_state_e w_state, w_state_next;
    r_state_e r_state, r_state_next;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state <= W_IDLE;
            r_state <= R_IDLE;
        end else begin
            w_state <= w_state_next;
            r_state <= r_state_next;
        end
    end

    // write channel
    always_comb begin
        w_state_next = w_state;
        case (w_state)
            W_IDLE:  if (wr_req_valid_i) w_state_next = W_AW;
            W_AW:    if (axi_aw_ready_i) w_state_next = W_DATA;
            W_DATA:  if (axi_w_ready_i && w_last_i) w_state_next = W_B;
            W_B:     if (axi_b_valid_i) w_state_next = W_IDLE;
            default: w_state_next = W_IDLE;
        endcase
    end

    assign axi_aw_valid_o = (w_state == W_AW);
    assign axi_w_valid_o  = (w_state == W_DATA);
    assign axi_b_ready_o  = (w_state == W_B);

    assign wr_req_taken_o = axi_aw_valid_o && axi_aw_ready_i;
    assign w_beat_adv_o   = axi_w_valid_o && axi_w_ready_i;
    assign b_done_o       = axi_b_valid_i && axi_b_ready_o;
    assign b_resp_o       = resp_e'(axi_b_i.resp);

    assign axi_aw_o = '{addr: {wr_req_i.line_addr, {`DC_OFFS_W{1'b0}}},
                        id: `DC_AXI_ID, len: `DC_AXI_LEN, size: `DC_AXI_SIZE,
                        burst: `DC_BURST_INCR, cache: `DC_AWCACHE, prot: `DC_PROT};

    assign axi_w_o = '{data: w_data_i, strb: '1, last: w_last_i};  // full lines only

    // read channel
    always_comb begin
        r_state_next = r_state;
        case (r_state)
            R_IDLE:  if (rd_req_valid_i) r_state_next = R_AR;
            R_AR:    if (axi_ar_ready_i) r_state_next = R_DATA;
            R_DATA:  if (axi_r_valid_i && axi_r_i.last) r_state_next = R_IDLE;
            default: r_state_next = R_IDLE;
        endcase
    end

    assign axi_ar_valid_o = (r_state == R_AR);
    assign axi_r_ready_o  = (r_state == R_DATA);

    assign rd_req_taken_o = axi_ar_valid_o && axi_ar_ready_i;
    assign r_beat_valid_o = axi_r_valid_i && axi_r_ready_o;
    assign r_beat_o       = axi_r_i;

    assign axi_ar_o = '{addr: {rd_req_i.line_addr, {`DC_OFFS_W{1'b0}}},
                        id: `DC_AXI_ID, len: `DC_AXI_LEN, size: `DC_AXI_SIZE,
                        burst: `DC_BURST_INCR, cache: `DC_ARCACHE, prot: `DC_PROT};

endmodule

/* src/dcache_line_buffer.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_line_buffer
    import axi_pkg::*;
    import dcache_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wb_load_i,
    input  line_data_u            wb_line_i,
    input  logic                  w_beat_adv_i,
    output logic [`DC_BEAT_W-1:0] w_data_o,
    output logic                  w_last_o,
    input  logic                  r_beat_valid_i,
    input  axi_r_t                r_beat_i,
    input  logic                  b_done_i,
    input  resp_e                 b_resp_i,
    output logic                  refill_done_o,
    output logic [`DC_LINE_W-1:0] refill_line_o,
    output logic                  refill_err_o,
    output logic                  wb_done_o,
    output logic                  wb_err_o
);

    line_data_u            wb_buf;
    logic [1:0]            w_cnt;      // beat index into wb_buf
    logic [`DC_LINE_W-1:0] rf_line;
    logic                  rf_err_acc;
    logic                  beat_err;

    // writeback side
    always_ff @(posedge clock) begin
        if (wb_load_i) wb_buf <= wb_line_i;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_cnt <= 2'd0;
        end else if (wb_load_i) begin
            w_cnt <= 2'd0;
        end else if (w_beat_adv_i) begin
            w_cnt <= w_cnt + 2'd1;    // wraps after the last beat
        end
    end

    assign w_data_o = wb_buf.beats[w_cnt];
    assign w_last_o = (w_cnt == 2'(`DC_LINE_BEATS - 1));

    // refill side, first beat ends up in the low bits
    always_ff @(posedge clock) begin
        if (r_beat_valid_i) begin
            rf_line <= {r_beat_i.data, rf_line[`DC_LINE_W-1:`DC_BEAT_W]};
        end
    end

    assign refill_line_o = rf_line;
    assign beat_err      = (resp_e'(r_beat_i.resp) != RESP_OKAY);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rf_err_acc    <= 1'b0;
            refill_done_o <= 1'b0;
            refill_err_o  <= 1'b0;
            wb_done_o     <= 1'b0;
            wb_err_o      <= 1'b0;
        end else begin
            refill_done_o <= r_beat_valid_i && r_beat_i.last;
            if (r_beat_valid_i) begin
                if (r_beat_i.last) begin
                    refill_err_o <= rf_err_acc | beat_err;
                    rf_err_acc   <= 1'b0;          // ready for the next line
                end else begin
                    rf_err_acc <= rf_err_acc | beat_err;
                end
            end
            wb_done_o <= b_done_i;
            if (b_done_i) wb_err_o <= (b_resp_i != RESP_OKAY);
        end
    end

endmodule

/* src/dcache_miss_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  refill_valid_i,
    input  logic [`DC_ADDR_W-1:0] refill_addr_i,
    output logic                  refill_ready_o,
    input  logic                  wb_valid_i,
    input  logic [`DC_ADDR_W-1:0] wb_addr_i,
    input  logic [`DC_LINE_W-1:0] wb_line_i,
    output logic                  wb_ready_o,
    output line_req_t             rd_req_o,
    output logic                  rd_req_valid_o,
    input  logic                  rd_req_taken_i,
    output line_req_t             wr_req_o,
    output logic                  wr_req_valid_o,
    input  logic                  wr_req_taken_i,
    input  logic                  b_done_i,
    output logic                  wb_load_o,
    output line_data_u            wb_line_o
);

    logic [LINE_ADDR_W-1:0] refill_line_addr;
    logic [LINE_ADDR_W-1:0] wb_line_addr;
    logic                   refill_take;
    logic                   wb_take;
    logic                   refill_hit_wb;
    logic                   rd_pend;       // waiting for AR handshake
    logic                   wr_pend;       // waiting for AW handshake
    logic                   wb_busy;       // accepted until B is seen
    line_req_t              rd_req_q;
    line_req_t              wr_req_q;

    assign refill_line_addr = refill_addr_i[`DC_ADDR_W-1:`DC_OFFS_W];
    assign wb_line_addr     = wb_addr_i[`DC_ADDR_W-1:`DC_OFFS_W];

    assign wb_ready_o = !wb_busy;
    assign wb_take    = wb_valid_i && wb_ready_o;

    // a refill may not read a line whose writeback has not landed yet
    assign refill_hit_wb = (wb_busy && wr_req_q.line_addr == refill_line_addr) ||
                           (wb_take && wb_line_addr == refill_line_addr);

    assign refill_ready_o = !rd_pend && !refill_hit_wb;
    assign refill_take    = refill_valid_i && refill_ready_o;

    // new request goes out at once and the registered copy holds it
    assign rd_req_valid_o = rd_pend || refill_take;
    assign rd_req_o       = rd_pend ? rd_req_q : line_req_t'{line_addr: refill_line_addr,
                                                             kind: KIND_REFILL};

    assign wr_req_valid_o = wr_pend || wb_take;
    assign wr_req_o       = wr_pend ? wr_req_q : line_req_t'{line_addr: wb_line_addr,
                                                             kind: KIND_WB};

    assign wb_load_o = wb_take;    // line goes to the buffer on acceptance
    assign wb_line_o = line_data_u'(wb_line_i);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
            wb_busy <= 1'b0;
        end else begin
            if (refill_take) begin
                rd_pend <= !rd_req_taken_i;
            end else if (rd_req_taken_i) begin
                rd_pend <= 1'b0;
            end
            if (wb_take) begin
                wr_pend <= !wr_req_taken_i;
                wb_busy <= 1'b1;
            end else begin
                if (wr_req_taken_i) wr_pend <= 1'b0;
                if (b_done_i) wb_busy <= 1'b0;   // memory now holds the line
            end
        end
    end

    always_ff @(posedge clock) begin
        if (refill_take) rd_req_q <= rd_req_o;
        if (wb_take) wr_req_q <= wr_req_o;   // line addr kept for the hazard check
    end

endmodule

/* src/dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

    localparam int LINE_ADDR_W = `DC_ADDR_W - `DC_OFFS_W;  // address without offset

    typedef enum logic {
        KIND_REFILL = 1'b0,
        KIND_WB     = 1'b1
    } req_kind_e;

    // one aligned line request
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        req_kind_e              kind;
    } line_req_t;

    // cache side sees a whole line, the beat counter sees four beats
    typedef union packed {
        logic [`DC_LINE_W-1:0]                    line;
        logic [`DC_LINE_BEATS-1:0][`DC_BEAT_W-1:0] beats;  // beat 0 in the low bits
    } line_data_u;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

endpackage

/* src/axi_pkg.sv */
`include "dcache_settings.svh"

package axi_pkg;

    // write address, 56 bits
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [3:0]            id;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic [3:0]            cache;
        logic [2:0]            prot;
    } axi_aw_t;

    // write data, 73 bits
    typedef struct packed {
        logic [`DC_BEAT_W-1:0]   data;
        logic [`DC_BEAT_W/8-1:0] strb;
        logic                    last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    // read address, same layout as aw
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [3:0]            id;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic [3:0]            cache;
        logic [2:0]            prot;
    } axi_ar_t;

    typedef struct packed {
        logic [`DC_BEAT_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
        logic [3:0]            id;
    } axi_r_t;

endpackage

/* src/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address and data geometry
`define DC_ADDR_W       32
`define DC_BEAT_W       64
`define DC_LINE_BEATS   4
`define DC_LINE_W       256
`define DC_OFFS_W       5      // byte offset inside a line

// fixed burst attributes
`define DC_AXI_ID       4'd1
`define DC_AXI_SIZE     3'd3   // 8 bytes per beat
`define DC_AXI_LEN      8'd3   // four beats
`define DC_BURST_INCR   2'b01

`define DC_AWCACHE      4'b1111  // write-back, read and write allocate
`define DC_ARCACHE      4'b0010  // normal non-cacheable non-bufferable
`define DC_PROT         3'b000   // unprivileged, secure, data

`endif
